// File: common/aes_defines.svh
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// block geometry
`define AES_BLOCK_W 128
`define AES_BYTES 16

// cipher parameters, 128-bit key
`define AES_ROUNDS 10
`define AES_RCON_INIT 8'h01

// low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
`define AES_POLY 8'h1B

`endif

// File: common/aes_types_pkg.sv
`include "aes_defines.svh"

package aes_types_pkg;

  // ------------------------------
  // basic widths
  // ------------------------------
  typedef logic [7:0] aes_byte_t;

  // one state column or one key word, first byte in the top bits
  typedef logic [31:0] aes_word_t;

  typedef logic [`AES_BLOCK_W-1:0] aes_block_t;

  // ------------------------------
  // state views
  // ------------------------------
  // bytes[15] is AES byte 0, bytes[0] is AES byte 15
  // cols[3] is column 0, cols[0] is column 3
  typedef union packed {
    aes_byte_t [`AES_BYTES-1:0] bytes;
    aes_word_t [3:0] cols;
  } aes_state_u;

endpackage

// File: common/gf_arith_pkg.sv
`include "aes_defines.svh"

package gf_arith_pkg;

  import aes_types_pkg::*;

  // ------------------------------
  // GF(2^2) with phi = 2'b10
  // ------------------------------
  function automatic logic [1:0] gf2_mul(input logic [1:0] x, input logic [1:0] y);
    return {(x[1] & y[1]) ^ (x[0] & y[1]) ^ (x[1] & y[0]), (x[1] & y[1]) ^ (x[0] & y[0])};
  endfunction

  function automatic logic [1:0] gf2_sq_phi(input logic [1:0] x);
    return gf2_mul(gf2_mul(x, x), 2'b10);
  endfunction

  // inverse equals the square in GF(2^2)
  function automatic logic [1:0] gf2_inv(input logic [1:0] x);
    return {x[1], x[1] ^ x[0]};
  endfunction

  // ------------------------------
  // GF((2^2)^2) with lambda = 4'b1100
  // ------------------------------
  function automatic logic [3:0] gf4_mul(input logic [3:0] x, input logic [3:0] y);
    logic [1:0] hh;
    hh = gf2_mul(x[3:2], y[3:2]);
    return {hh ^ gf2_mul(x[3:2], y[1:0]) ^ gf2_mul(x[1:0], y[3:2]),
            gf2_mul(hh, 2'b10) ^ gf2_mul(x[1:0], y[1:0])};
  endfunction

  function automatic logic [3:0] gf4_sq_lambda(input logic [3:0] x);
    return gf4_mul(gf4_mul(x, x), 4'b1100);
  endfunction

  function automatic logic [3:0] gf4_inv(input logic [3:0] x);
    logic [1:0] g_sum;
    logic [1:0] p_inv;
    g_sum = x[3:2] ^ x[1:0];
    p_inv = gf2_inv(gf2_sq_phi(x[3:2]) ^ gf2_mul(g_sum, x[1:0]));
    return {gf2_mul(x[3:2], p_inv), gf2_mul(g_sum, p_inv)};
  endfunction

  // ------------------------------
  // basis change, row masks by output bit 0..7
  // ------------------------------
  localparam aes_byte_t ISO_FWD [8] = '{8'h43, 8'h52, 8'h9E, 8'hC6, 8'hAE, 8'hAC, 8'hDE, 8'hA0};
  localparam aes_byte_t ISO_INV [8] = '{8'h75, 8'h30, 8'h9E, 8'h3E, 8'h76, 8'h62, 8'h44, 8'hE2};
  localparam aes_byte_t AFFINE_C = 8'h63;

  function automatic aes_byte_t map_to_composite(input aes_byte_t x);
    aes_byte_t y;
    for (int i = 0; i < 8; i++) begin
      y[i] = ^(x & ISO_FWD[i]);
    end
    return y;
  endfunction

  function automatic aes_byte_t map_from_composite(input aes_byte_t x);
    aes_byte_t y;
    for (int i = 0; i < 8; i++) begin
      y[i] = ^(x & ISO_INV[i]);
    end
    return y;
  endfunction

  // byte xor four left rotations, then the constant
  function automatic aes_byte_t affine(input aes_byte_t x);
    return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]} ^ {x[3:0], x[7:4]} ^ AFFINE_C;
  endfunction

  // ------------------------------
  // GF(2^8) column arithmetic
  // ------------------------------
  function automatic aes_byte_t xtime(input aes_byte_t x);
    return {x[6:0], 1'b0} ^ (x[7] ? `AES_POLY : 8'h00);
  endfunction

  function automatic aes_word_t mix_column(input aes_word_t col);
    aes_byte_t a0, a1, a2, a3, t;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    t  = a0 ^ a1 ^ a2 ^ a3;
    return {a0 ^ t ^ xtime(a0 ^ a1), a1 ^ t ^ xtime(a1 ^ a2),
            a2 ^ t ^ xtime(a2 ^ a3), a3 ^ t ^ xtime(a3 ^ a0)};
  endfunction

endpackage

// File: common/round_ctrl_if.sv
`timescale 1ns/1ps

interface round_ctrl_if
  import aes_types_pkg::*;
(
  input logic en
);

  logic load_block;
  logic key_restart;
  logic round_step;
  logic final_round;
  aes_byte_t rcon;

  modport ctrl (input en, output load_block, key_restart, round_step, final_round, rcon);

  // state register side
  modport state (input en, load_block, round_step, final_round);

  // round key side
  modport key (input en, key_restart, rcon);

endinterface

// File: verilog/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox
  import aes_types_pkg::*;
  import gf_arith_pkg::*;
(
  input  aes_byte_t in_byte,
  output aes_byte_t out_byte
);

  aes_byte_t comp;
  aes_byte_t comp_inv;
  logic [3:0] g1;
  logic [3:0] g0;
  logic [3:0] g_sum;
  logic [3:0] p;
  logic [3:0] p_inv;

  // ------------------------------
  // into GF((2^4)^2)
  // ------------------------------
  assign comp  = map_to_composite(in_byte);
  assign g1    = comp[7:4];
  assign g0    = comp[3:0];
  assign g_sum = g1 ^ g0;

  // norm of g1*y + g0, inverted in the subfield
  assign p     = gf4_sq_lambda(g1) ^ gf4_mul(g_sum, g0);
  assign p_inv = gf4_inv(p);

  assign comp_inv = {gf4_mul(g1, p_inv), gf4_mul(g_sum, p_inv)};

  // ------------------------------
  // back to GF(2^8), then affine
  // ------------------------------
  assign out_byte = affine(map_from_composite(comp_inv));

endmodule

// File: cipher/aes_round.sv
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_round
  import aes_types_pkg::*;
  import gf_arith_pkg::*;
(
  input  aes_state_u state_in,
  input  aes_state_u round_key,
  input  logic       final_round,
  output aes_state_u state_out
);

  aes_state_u sub_bytes;
  aes_state_u shifted;

  // ------------------------------
  // SubBytes
  // ------------------------------
  for (genvar i = 0; i < `AES_BYTES; i++) begin : g_sbox
    aes_sbox u_sbox (
      .in_byte  (state_in.bytes[i]),
      .out_byte (sub_bytes.bytes[i])
    );
  end

  // ------------------------------
  // ShiftRows
  // ------------------------------
  // AES byte r + 4c takes byte r + 4((c + r) mod 4)
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[`AES_BYTES-1 - (r + 4*c)] =
          sub_bytes.bytes[`AES_BYTES-1 - (r + 4*((c + r) % 4))];
      end
    end
  end

  // ------------------------------
  // MixColumns and AddRoundKey
  // ------------------------------
  always_comb begin
    aes_word_t col;
    for (int c = 0; c < 4; c++) begin
      col = final_round ? shifted.cols[c] : mix_column(shifted.cols[c]);
      state_out.cols[c] = col ^ round_key.cols[c];
    end
  end

endmodule

// File: cipher/aes_state_path.sv
`timescale 1ns/1ps

module aes_state_path
  import aes_types_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  round_ctrl_if.state rc,
  input  aes_block_t data_in,
  input  aes_block_t stored_key,
  input  aes_block_t round_key_next,
  output aes_block_t data_out
);

  aes_block_t state_q;
  aes_state_u round_out;

  aes_round u_round (
    .state_in    (state_q),
    .round_key   (round_key_next),
    .final_round (rc.final_round),
    .state_out   (round_out)
  );

  // initial whitening on load, one round per step
  always_ff @(posedge CLK or posedge rst) begin
    if (rst) begin
      state_q <= '0;
    end else if (rc.en) begin
      if (rc.load_block) begin
        state_q <= data_in ^ stored_key;
      end else if (rc.round_step) begin
        state_q <= round_out;
      end
    end
  end

  // ciphertext stays here until the next load
  assign data_out = state_q;

  a_state_hold: assert property (@(posedge CLK) disable iff (rst)
    !rc.en |=> $stable(state_q));

endmodule

// File: keygen/aes_key_sched.sv
`timescale 1ns/1ps

module aes_key_sched
  import aes_types_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  round_ctrl_if.key  rc,
  input  aes_block_t key_in,
  input  logic       key_ready,
  output aes_block_t stored_key,
  output aes_block_t round_key_next
);

  aes_block_t key_q;
  aes_block_t rkey_q;
  aes_word_t rot_word;
  aes_word_t sub_word;
  aes_word_t w0, w1, w2, w3;

  // RotWord of the last key word, then SubWord
  assign rot_word = {rkey_q[23:0], rkey_q[31:24]};

  for (genvar i = 0; i < 4; i++) begin : g_sbox
    aes_sbox u_sbox (
      .in_byte  (rot_word[8*i +: 8]),
      .out_byte (sub_word[8*i +: 8])
    );
  end

  // ------------------------------
  // four-word chain
  // ------------------------------
  assign w0 = rkey_q[127:96] ^ sub_word ^ {rc.rcon, 24'h0};
  assign w1 = rkey_q[95:64] ^ w0;
  assign w2 = rkey_q[63:32] ^ w1;
  assign w3 = rkey_q[31:0] ^ w2;

  assign round_key_next = {w0, w1, w2, w3};
  assign stored_key     = key_q;

  always_ff @(posedge CLK or posedge rst) begin
    if (rst) begin
      key_q  <= '0;
      rkey_q <= '0;
    end else if (rc.en) begin
      if (key_ready) begin
        key_q  <= key_in;
        rkey_q <= key_in;
      end else if (rc.key_restart) begin
        rkey_q <= key_q;
      end else begin
        rkey_q <= round_key_next;
      end
    end
  end

endmodule

// File: verilog/aes_round_ctrl.sv
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_round_ctrl
  import aes_types_pkg::*;
  import gf_arith_pkg::*;
(
  input  logic CLK,
  input  logic rst,
  input  logic key_ready,
  input  logic data_ready,
  round_ctrl_if.ctrl rc,
  output logic key_valid,
  output logic data_valid,
  output logic busy
);

  // bit 0 marks idle, bits 1..9 mark rounds 1..9
  logic [`AES_ROUNDS-1:0] rnd_q;
  logic final_q;
  aes_byte_t rcon_q;
  logic idle;

  assign idle = rnd_q[0];

  // ------------------------------
  // strobes
  // ------------------------------
  assign rc.load_block  = data_ready & ~busy;
  assign rc.key_restart = idle;
  assign rc.round_step  = ~idle | final_q;
  assign rc.final_round = final_q;
  assign rc.rcon        = rcon_q;

  always_ff @(posedge CLK or posedge rst) begin
    if (rst) begin
      rnd_q      <= `AES_ROUNDS'(1);
      final_q    <= 1'b0;
      rcon_q     <= `AES_RCON_INIT;
      key_valid  <= 1'b0;
      data_valid <= 1'b0;
      busy       <= 1'b0;
    end else if (rc.en) begin
      if (rc.load_block || !idle) begin
        rnd_q <= {rnd_q[`AES_ROUNDS-2:0], rnd_q[`AES_ROUNDS-1]};
      end
      // final round follows the last one-hot position
      final_q <= rnd_q[`AES_ROUNDS-1];
      if (rc.load_block) begin
        rcon_q <= `AES_RCON_INIT;
      end else if (!idle) begin
        rcon_q <= xtime(rcon_q);
      end
      key_valid  <= key_ready;
      data_valid <= final_q;
      busy       <= rc.load_block | (|rnd_q[`AES_ROUNDS-1:1]) | final_q;
    end
  end

  a_rnd_onehot: assert property (@(posedge CLK) disable iff (rst) $onehot(rnd_q));

  // busy must cover every cycle in which a round is pending
  a_load_vs_step: assert property (@(posedge CLK) disable iff (rst)
    !(rc.load_block && rc.round_step));

endmodule

// File: verilog/aes_enc_top.sv
`timescale 1ns/1ps

module aes_enc_top
  import aes_types_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic       en,
  input  aes_block_t key_in,
  input  aes_block_t data_in,
  input  logic       key_ready,
  input  logic       data_ready,
  output aes_block_t data_out,
  output logic       key_valid,
  output logic       data_valid,
  output logic       busy
);

  aes_block_t stored_key;
  aes_block_t round_key_next;

  // round strobes, shared by both datapaths
  round_ctrl_if rc (
    .en(en)
  );

  // ------------------------------
  // sequencer
  // ------------------------------
  aes_round_ctrl u_ctrl (
    .CLK        (CLK),
    .rst        (rst),
    .key_ready  (key_ready),
    .data_ready (data_ready),
    .rc         (rc.ctrl),
    .key_valid  (key_valid),
    .data_valid (data_valid),
    .busy       (busy)
  );

  // ------------------------------
  // datapaths
  // ------------------------------
  aes_state_path u_state (
    .CLK            (CLK),
    .rst            (rst),
    .rc             (rc.state),
    .data_in        (data_in),
    .stored_key     (stored_key),
    .round_key_next (round_key_next),
    .data_out       (data_out)
  );

  aes_key_sched u_key (
    .CLK            (CLK),
    .rst            (rst),
    .rc             (rc.key),
    .key_in         (key_in),
    .key_ready      (key_ready),
    .stored_key     (stored_key),
    .round_key_next (round_key_next)
  );

endmodule

// File: bench/tb_aes_enc.sv
`timescale 1ns/1ps
`include "aes_defines.svh"

module tb_aes_enc
  import aes_types_pkg::*;
;

  localparam int RESET_CYCLES = 5;
  localparam int MAX_STALL    = 3 * 7;
  localparam int WAIT_LIMIT   = `AES_ROUNDS + MAX_STALL + 4;
  localparam int KEY_CYCLES   = 4;
  localparam int BLOCK_CYCLES = `AES_ROUNDS + 5;
  // reset, three key loads, six blocks, stall budget
  localparam int TEST_CYCLES  = RESET_CYCLES + 2 + 3 * KEY_CYCLES + 6 * BLOCK_CYCLES + MAX_STALL;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  localparam aes_block_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_block_t PT_A  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_block_t CT_A  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aes_block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam aes_block_t PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam aes_block_t CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;
  // ECB known answer under the same key
  localparam aes_block_t PT_C  = 128'h6bc1bee22e409f96e93d7e117393172a;
  localparam aes_block_t CT_C  = 128'h3ad77bb40d7a3660a89ecaf32466ef97;

  logic CLK;
  logic rst;
  logic en;
  aes_block_t key_in;
  aes_block_t data_in;
  logic key_ready;
  logic data_ready;
  aes_block_t data_out;
  logic key_valid;
  logic data_valid;
  logic busy;

  int errors;
  int checks;
  int cycle_cnt;
  logic [31:0] lfsr_q;
  logic en_sched [0:63];

  aes_enc_top uut (
    .CLK        (CLK),
    .rst        (rst),
    .en         (en),
    .key_in     (key_in),
    .data_in    (data_in),
    .key_ready  (key_ready),
    .data_ready (data_ready),
    .data_out   (data_out),
    .key_valid  (key_valid),
    .data_valid (data_valid),
    .busy       (busy)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles, %0d errors so far", TIMEOUT_CYCLES, errors);
      $display("Done: errors found");
      $finish;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  // en value per edge after E0, low runs of 1 to 7 cycles
  task automatic plan_stalls(input int n_stalls, output int total);
    int p;
    int len;
    for (int i = 0; i < 64; i++) begin
      en_sched[i] = 1'b1;
    end
    total = 0;
    p = 1;
    for (int k = 0; k < n_stalls; k++) begin
      p = p + 1 + take_bits(1);
      len = 1 + (take_bits(3) % 7);
      for (int j = 0; j < len; j++) begin
        en_sched[p + j] = 1'b0;
      end
      p = p + len;
      total = total + len;
    end
  endtask

  task automatic load_key(input aes_block_t key);
    @(posedge CLK);
    key_in    <= key;
    key_ready <= 1'b1;
    @(posedge CLK);
    key_ready <= 1'b0;
    @(negedge CLK);
    check_value(key_valid, 1'b1, "key_valid one edge after key_ready");
    @(posedge CLK);
    @(negedge CLK);
    check_value(key_valid, 1'b0, "key_valid lasts one cycle");
  endtask

  task automatic run_block(input aes_block_t pt, input aes_block_t exp, input int n_stalls,
                           input string name);
    int edges;
    int stall_total;
    plan_stalls(n_stalls, stall_total);
    @(posedge CLK);
    data_in    <= pt;
    data_ready <= 1'b1;
    // this edge is E0
    @(posedge CLK);
    data_ready <= 1'b0;
    en         <= en_sched[1];
    edges = 0;
    @(negedge CLK);
    while (!data_valid && edges < WAIT_LIMIT) begin
      @(posedge CLK);
      edges++;
      en <= en_sched[edges + 1];
      @(negedge CLK);
    end
    if (!data_valid) begin
      errors++;
      $display("data_valid did not rise within %0d cycles for %s", WAIT_LIMIT, name);
    end else begin
      check_value(edges, `AES_ROUNDS + stall_total, {name, ": data_valid edge"});
      check_value(data_out, exp, {name, ": ciphertext"});
    end
    @(posedge CLK);
    @(negedge CLK);
    check_value(data_valid, 1'b0, {name, ": data_valid is one pulse"});
    check_value(data_out, exp, {name, ": ciphertext holds"});
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_state();
    @(negedge CLK);
    check_value(data_valid, 1'b0, "data_valid after reset");
    check_value(key_valid, 1'b0, "key_valid after reset");
    check_value(busy, 1'b0, "busy after reset");
  endtask

  task automatic key_load();
    aes_block_t key;
    key = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
    check_value(key_valid, 1'b0, "key_valid before load");
    load_key(key);
  endtask

  task automatic fips_vectors();
    load_key(KEY_A);
    run_block(PT_A, CT_A, 0, "fips key A");
    load_key(KEY_B);
    run_block(PT_B, CT_B, 0, "fips key B");
  endtask

  // no key load, stored key B must still be in place
  task automatic key_reuse();
    run_block(PT_C, CT_C, 0, "reuse second block");
    run_block(PT_B, CT_B, 0, "reuse first plaintext");
  endtask

  task automatic busy_window();
    @(negedge CLK);
    check_value(busy, 1'b0, "busy before E0");
    @(posedge CLK);
    data_in    <= PT_B;
    data_ready <= 1'b1;
    @(posedge CLK);
    data_ready <= 1'b0;
    for (int k = 0; k <= `AES_ROUNDS; k++) begin
      @(negedge CLK);
      check_value(busy, 1'b1, $sformatf("busy after E%0d", k));
      @(posedge CLK);
    end
    @(negedge CLK);
    check_value(busy, 1'b0, "busy after E11");
    check_value(data_out, CT_B, "busy window ciphertext");
  endtask

  task automatic stall();
    run_block(PT_C, CT_C, 3, "stalled block");
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    CLK        = 1'b0;
    rst        = 1'b1;
    en         = 1'b1;
    key_in     = '0;
    data_in    = '0;
    key_ready  = 1'b0;
    data_ready = 1'b0;
    errors     = 0;
    checks     = 0;
    cycle_cnt  = 0;
    lfsr_q     = 32'h87cd_7667;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst <= 1'b0;

    reset_state();
    key_load();
    fips_vectors();
    key_reuse();
    busy_window();
    stall();

    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/aes_types_pkg.sv
common/gf_arith_pkg.sv
common/round_ctrl_if.sv
verilog/aes_sbox.sv
cipher/aes_round.sv
cipher/aes_state_path.sv
keygen/aes_key_sched.sv
verilog/aes_round_ctrl.sv
verilog/aes_enc_top.sv
bench/tb_aes_enc.sv

// File: Bender.yml
package:
  name: aes_enc

sources:
  - include_dirs:
      - common
    files:
      - common/aes_types_pkg.sv
      - common/gf_arith_pkg.sv
      - common/round_ctrl_if.sv
      - verilog/aes_sbox.sv
      - cipher/aes_round.sv
      - cipher/aes_state_path.sv
      - keygen/aes_key_sched.sv
      - verilog/aes_round_ctrl.sv
      - verilog/aes_enc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_aes_enc.sv
